//--- design/share_config.svh
`ifndef SHARE_CONFIG_SVH
`define SHARE_CONFIG_SVH

// Width of one data word in either byte queue
`define SHARE_BYTE_W 8

// Queue depths in entries, each kept a power of two
`define SHARE_TX_QUEUE_DEPTH 16
`define SHARE_RX_QUEUE_DEPTH 16

`endif

//--- design/share_pkg.sv
`default_nettype none

`include "share_config.svh"

package share_pkg;

  typedef enum logic [1:0] {
    APP_OWNER_NONE = 2'b00,
    APP_OWNER_IP   = 2'b01,
    APP_OWNER_CPU  = 2'b10
  } app_owner_e;

  typedef enum logic {
    BUF_OWNER_IP  = 1'b0,
    BUF_OWNER_CPU = 1'b1
  } buf_owner_e;

  typedef struct packed {
    logic req;  // Held until the grant is seen
    logic rel;  // One-cycle pulse while holding the grant
  } share_ctl_t;

  typedef struct packed {
    logic ip;
    logic cpu;
  } grant_pair_t;

  typedef struct packed {
    logic                     valid;
    logic [`SHARE_BYTE_W-1:0] data;
  } byte_wr_t;

endpackage

`default_nettype wire

//--- design/app_data_arbiter.sv
`default_nettype none
`timescale 1ns/1ns

module app_data_arbiter (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         i_enable,
  input  wire share_pkg::share_ctl_t  i_ip,
  input  wire share_pkg::share_ctl_t  i_cpu,
  output share_pkg::grant_pair_t      o_grant
);

  share_pkg::app_owner_e owner_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q <= share_pkg::APP_OWNER_NONE;
    end else begin
      case (owner_q)
        share_pkg::APP_OWNER_NONE: begin
          if (i_ip.req) begin
            owner_q <= share_pkg::APP_OWNER_IP;  // IP side wins a tie
          end else if (i_cpu.req) begin
            owner_q <= share_pkg::APP_OWNER_CPU;
          end
        end
        share_pkg::APP_OWNER_IP: begin
          if (i_ip.rel) begin
            owner_q <= share_pkg::APP_OWNER_NONE;  // CPU release ignored here
          end
        end
        share_pkg::APP_OWNER_CPU: begin
          if (i_cpu.rel) begin
            owner_q <= share_pkg::APP_OWNER_NONE;
          end
        end
        default: begin
          owner_q <= share_pkg::APP_OWNER_NONE;
        end
      endcase
    end
  end

  // State keeps moving with the enable low, only the view is masked
  always_comb begin
    o_grant.ip  = i_enable & (owner_q == share_pkg::APP_OWNER_IP);
    o_grant.cpu = i_enable & (owner_q == share_pkg::APP_OWNER_CPU);
  end

endmodule

`default_nettype wire

//--- design/buf_owner_toggle.sv
`default_nettype none
`timescale 1ns/1ns

module buf_owner_toggle #(
  parameter share_pkg::buf_owner_e RESET_OWNER = share_pkg::BUF_OWNER_IP
) (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     i_enable,
  input  wire                     i_ip_rel,
  input  wire                     i_cpu_rel,
  output share_pkg::grant_pair_t  o_grant
);

  share_pkg::buf_owner_e owner_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      owner_q <= RESET_OWNER;
    end else begin
      case (owner_q)
        share_pkg::BUF_OWNER_IP: begin
          if (i_ip_rel) begin
            owner_q <= share_pkg::BUF_OWNER_CPU;
          end
        end
        share_pkg::BUF_OWNER_CPU: begin
          if (i_cpu_rel) begin
            owner_q <= share_pkg::BUF_OWNER_IP;
          end
        end
        default: begin
          owner_q <= RESET_OWNER;
        end
      endcase
    end
  end

  always_comb begin
    o_grant.ip  = i_enable & (owner_q == share_pkg::BUF_OWNER_IP);
    o_grant.cpu = i_enable & (owner_q == share_pkg::BUF_OWNER_CPU);
  end

endmodule

`default_nettype wire

//--- design/byte_queue.sv
`default_nettype none
`timescale 1ns/1ns

`include "share_config.svh"

module byte_queue #(
  parameter int DEPTH = 16
) (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire share_pkg::byte_wr_t  i_wr,
  input  wire                       i_rd,
  output logic [`SHARE_BYTE_W-1:0]  o_data,
  output logic                      o_empty,
  output logic                      o_full
);

  localparam int AW = $clog2(DEPTH);

  logic [`SHARE_BYTE_W-1:0] mem [DEPTH];
  logic [AW-1:0]            wr_ptr;
  logic [AW-1:0]            rd_ptr;
  logic [AW:0]              count;
  logic                     wr_go;
  logic                     rd_go;

  assign o_empty = (count == '0);
  assign o_full  = (count == (AW+1)'(DEPTH));

  assign wr_go = i_wr.valid & ~o_full;  // Dropped when full
  assign rd_go = i_rd & ~o_empty;       // No effect when empty

  // Head entry shows without a read cycle
  assign o_data = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (wr_go) begin
      mem[wr_ptr] <= i_wr.data;
    end
  end

  // ************************************************************
  // Pointers and occupancy
  // ************************************************************
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_go) begin
        wr_ptr <= wr_ptr + 1'b1;  // Wraps since depth is a power of two
      end
      if (rd_go) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_go, rd_go})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;  // Both or neither leave the count alone
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/ros2_share_top.sv
`default_nettype none
`timescale 1ns/1ns

`include "share_config.svh"

module ros2_share_top (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire                         i_ether_en,

  input  wire share_pkg::share_ctl_t  i_app_ip,
  input  wire share_pkg::share_ctl_t  i_app_cpu,
  input  wire share_pkg::share_ctl_t  i_rxbuf_ip,
  input  wire share_pkg::share_ctl_t  i_rxbuf_cpu,
  input  wire share_pkg::share_ctl_t  i_txbuf_ip,
  input  wire share_pkg::share_ctl_t  i_txbuf_cpu,

  output share_pkg::grant_pair_t      o_app_grant,
  output share_pkg::grant_pair_t      o_rxbuf_grant,
  output share_pkg::grant_pair_t      o_txbuf_grant,

  input  wire share_pkg::byte_wr_t    i_tx_wr,
  input  wire                         i_tx_rd,
  output logic [`SHARE_BYTE_W-1:0]    o_tx_data,
  output logic                        o_tx_empty,
  output logic                        o_tx_full,

  input  wire share_pkg::byte_wr_t    i_rx_wr,
  input  wire                         i_rx_rd,
  output logic [`SHARE_BYTE_W-1:0]    o_rx_data,
  output logic                        o_rx_empty,
  output logic                        o_rx_full
);

  // ************************************************************
  // Shared resource owners
  // ************************************************************
  app_data_arbiter app_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .i_enable (i_ether_en),
    .i_ip     (i_app_ip),
    .i_cpu    (i_app_cpu),
    .o_grant  (o_app_grant)
  );

  buf_owner_toggle #(
    .RESET_OWNER (share_pkg::BUF_OWNER_IP)  // IP side fills the RX buffer first
  ) rxbuf_owner (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_enable  (i_ether_en),
    .i_ip_rel  (i_rxbuf_ip.rel),
    .i_cpu_rel (i_rxbuf_cpu.rel),
    .o_grant   (o_rxbuf_grant)
  );

  buf_owner_toggle #(
    .RESET_OWNER (share_pkg::BUF_OWNER_CPU)  // CPU fills the TX buffer first
  ) txbuf_owner (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_enable  (i_ether_en),
    .i_ip_rel  (i_txbuf_ip.rel),
    .i_cpu_rel (i_txbuf_cpu.rel),
    .o_grant   (o_txbuf_grant)
  );

  // ************************************************************
  // Byte queues between IP side and Ethernet side
  // ************************************************************
  byte_queue #(
    .DEPTH (`SHARE_TX_QUEUE_DEPTH)
  ) tx_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr    (i_tx_wr),
    .i_rd    (i_tx_rd),
    .o_data  (o_tx_data),
    .o_empty (o_tx_empty),
    .o_full  (o_tx_full)
  );

  byte_queue #(
    .DEPTH (`SHARE_RX_QUEUE_DEPTH)
  ) rx_queue (
    .clk     (clk),
    .rst_n   (rst_n),
    .i_wr    (i_rx_wr),
    .i_rd    (i_rx_rd),
    .o_data  (o_rx_data),
    .o_empty (o_rx_empty),
    .o_full  (o_rx_full)
  );

endmodule

`default_nettype wire

//--- dv/ros2_share_props.sv
`default_nettype none
`timescale 1ns/1ns

`include "share_config.svh"

module ros2_share_props (
  input wire                         clk,
  input wire                         rst_n,
  input wire                         i_ether_en,
  input wire share_pkg::grant_pair_t o_app_grant,
  input wire share_pkg::grant_pair_t o_rxbuf_grant,
  input wire share_pkg::grant_pair_t o_txbuf_grant,
  input wire share_pkg::byte_wr_t    i_tx_wr,
  input wire                         i_tx_rd,
  input wire [`SHARE_BYTE_W-1:0]     o_tx_data,
  input wire                         o_tx_empty,
  input wire                         o_tx_full,
  input wire share_pkg::byte_wr_t    i_rx_wr,
  input wire                         i_rx_rd,
  input wire [`SHARE_BYTE_W-1:0]     o_rx_data,
  input wire                         o_rx_empty,
  input wire                         o_rx_full
);

  int fail_count = 0;  // Polled by the testbench top

  a_grant_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(o_app_grant.ip && o_app_grant.cpu) && !(o_rxbuf_grant.ip && o_rxbuf_grant.cpu)
      && !(o_txbuf_grant.ip && o_txbuf_grant.cpu))
    else begin
      $error("Both lines of a grant pair are high");
      fail_count = fail_count + 1;
    end

  a_grant_masked: assert property (@(posedge clk) disable iff (!rst_n)
    !i_ether_en |-> ({o_app_grant, o_rxbuf_grant, o_txbuf_grant} == 6'b0))
    else begin
      $error("Grant high while the Ethernet enable is low");
      fail_count = fail_count + 1;
    end

  a_queue_flags: assert property (@(posedge clk) disable iff (!rst_n)
    !(o_tx_empty && o_tx_full) && !(o_rx_empty && o_rx_full))
    else begin
      $error("Queue reports empty and full together");
      fail_count = fail_count + 1;
    end

  // Head data of an idle, non-empty queue must hold
  a_tx_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (!i_tx_wr.valid && !i_tx_rd && !o_tx_empty) |=> $stable(o_tx_data))
    else begin
      $error("TX head data changed without a queue access");
      fail_count = fail_count + 1;
    end

  a_rx_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (!i_rx_wr.valid && !i_rx_rd && !o_rx_empty) |=> $stable(o_rx_data))
    else begin
      $error("RX head data changed without a queue access");
      fail_count = fail_count + 1;
    end

endmodule

bind ros2_share_top ros2_share_props props (.*);

`default_nettype wire

//--- dv/tb_ros2_share.sv
`default_nettype none
`timescale 1ns/1ns

`include "share_config.svh"

module tb_ros2_share;

  localparam int TABLE_ROWS   = 14;
  localparam int DEPTH        = `SHARE_TX_QUEUE_DEPTH;
  localparam int QUEUE_CYCLES = 2 * DEPTH + 16;
  localparam int CYCLE_LIMIT  = 2 * TABLE_ROWS + QUEUE_CYCLES + 100;

  typedef struct packed {
    logic                   en;
    share_pkg::share_ctl_t  app_ip;
    share_pkg::share_ctl_t  app_cpu;
    logic                   rx_ip_rel;
    logic                   rx_cpu_rel;
    logic                   tx_ip_rel;
    logic                   tx_cpu_rel;
    share_pkg::grant_pair_t exp_app;
    share_pkg::grant_pair_t exp_rx;
    share_pkg::grant_pair_t exp_tx;
  } row_t;

  logic clk = 1'b0;
  logic rst_n;
  logic ether_en;
  share_pkg::share_ctl_t app_ip, app_cpu, rxbuf_ip, rxbuf_cpu, txbuf_ip, txbuf_cpu;
  share_pkg::grant_pair_t app_grant, rxbuf_grant, txbuf_grant;
  share_pkg::byte_wr_t tx_wr, rx_wr;
  logic tx_rd, rx_rd;
  logic [`SHARE_BYTE_W-1:0] tx_data, rx_data;
  logic tx_empty, tx_full, rx_empty, rx_full;

  row_t stim [TABLE_ROWS];
  int   n_rows = 0;
  int   cycles = 0;
  int   app_st = 0;      // 0 none, 1 IP, 2 CPU
  logic rx_own = 1'b0;   // 0 IP, 1 CPU
  logic tx_own = 1'b1;
  logic [`SHARE_BYTE_W-1:0] tx_model [$];
  logic [`SHARE_BYTE_W-1:0] rx_model [$];

  ros2_share_top uut (
    .clk (clk), .rst_n (rst_n), .i_ether_en (ether_en),
    .i_app_ip (app_ip), .i_app_cpu (app_cpu),
    .i_rxbuf_ip (rxbuf_ip), .i_rxbuf_cpu (rxbuf_cpu),
    .i_txbuf_ip (txbuf_ip), .i_txbuf_cpu (txbuf_cpu),
    .o_app_grant (app_grant), .o_rxbuf_grant (rxbuf_grant), .o_txbuf_grant (txbuf_grant),
    .i_tx_wr (tx_wr), .i_tx_rd (tx_rd), .o_tx_data (tx_data),
    .o_tx_empty (tx_empty), .o_tx_full (tx_full),
    .i_rx_wr (rx_wr), .i_rx_rd (rx_rd), .o_rx_data (rx_data),
    .o_rx_empty (rx_empty), .o_rx_full (rx_full)
  );

  always #2 clk = ~clk;

  // ************************************************************
  // Failure handling and compare tasks
  // ************************************************************
  task automatic stop_run();
    $display("Errors found");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_grant(input string name, input share_pkg::grant_pair_t got,
                             input share_pkg::grant_pair_t exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_byte(input string name, input logic [`SHARE_BYTE_W-1:0] got,
                            input logic [`SHARE_BYTE_W-1:0] exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
      stop_run();
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_run();
    end
  end

  always @(negedge clk) begin
    if (uut.props.fail_count != 0) begin
      $display("A property assertion on the DUT failed");
      stop_run();
    end
  end

  // ************************************************************
  // Reference model feeding the stimulus table
  // ************************************************************
  task automatic add_row(input logic en, input logic ip_req, input logic ip_rel,
                         input logic cpu_req, input logic cpu_rel, input logic rxi,
                         input logic rxc, input logic txi, input logic txc);
    row_t r;
    r = '0;
    r.en = en;
    r.app_ip = {ip_req, ip_rel};
    r.app_cpu = {cpu_req, cpu_rel};
    r.rx_ip_rel = rxi;
    r.rx_cpu_rel = rxc;
    r.tx_ip_rel = txi;
    r.tx_cpu_rel = txc;
    if (app_st == 0) begin
      app_st = ip_req ? 1 : (cpu_req ? 2 : 0);  // IP wins a tie
    end else if ((app_st == 1 && ip_rel) || (app_st == 2 && cpu_rel)) begin
      app_st = 0;
    end
    if ((!rx_own && rxi) || (rx_own && rxc)) begin
      rx_own = ~rx_own;
    end
    if ((!tx_own && txi) || (tx_own && txc)) begin
      tx_own = ~tx_own;
    end
    r.exp_app = {en && app_st == 1, en && app_st == 2};
    r.exp_rx = {en && !rx_own, en && rx_own};
    r.exp_tx = {en && !tx_own, en && tx_own};
    stim[n_rows] = r;
    n_rows++;
  endtask

  task automatic clear_ctl();
    app_ip <= '0;
    app_cpu <= '0;
    rxbuf_ip <= '0;
    rxbuf_cpu <= '0;
    txbuf_ip <= '0;
    txbuf_cpu <= '0;
  endtask

  task automatic run_table();
    for (int i = 0; i < n_rows; i++) begin
      @(posedge clk);
      ether_en <= stim[i].en;
      app_ip <= stim[i].app_ip;
      app_cpu <= stim[i].app_cpu;
      rxbuf_ip.rel <= stim[i].rx_ip_rel;
      rxbuf_cpu.rel <= stim[i].rx_cpu_rel;
      txbuf_ip.rel <= stim[i].tx_ip_rel;
      txbuf_cpu.rel <= stim[i].tx_cpu_rel;
      @(posedge clk);
      clear_ctl();  // Row sampled on this edge
      @(negedge clk);
      check_grant("o_app_grant", app_grant, stim[i].exp_app);
      check_grant("o_rxbuf_grant", rxbuf_grant, stim[i].exp_rx);
      check_grant("o_txbuf_grant", txbuf_grant, stim[i].exp_tx);
    end
  endtask

  task automatic check_queue_flags(input logic exp_empty, input logic exp_full);
    check_flag("o_tx_empty", tx_empty, exp_empty);
    check_flag("o_rx_empty", rx_empty, exp_empty);
    check_flag("o_tx_full", tx_full, exp_full);
    check_flag("o_rx_full", rx_full, exp_full);
  endtask

  task automatic run_queue_test();
    logic [31:0] r;
    for (int k = 0; k < DEPTH; k++) begin
      @(posedge clk);
      r = $urandom;
      tx_wr <= {1'b1, r[`SHARE_BYTE_W-1:0]};
      rx_wr <= {1'b1, r[2*`SHARE_BYTE_W-1:`SHARE_BYTE_W]};
      tx_model.push_back(r[`SHARE_BYTE_W-1:0]);
      rx_model.push_back(r[2*`SHARE_BYTE_W-1:`SHARE_BYTE_W]);
    end
    @(posedge clk);
    tx_wr <= {1'b1, 8'hA5};  // Lands on a full queue
    rx_wr <= {1'b1, 8'h5A};
    @(posedge clk);
    tx_wr <= '0;
    rx_wr <= '0;
    @(negedge clk);
    check_queue_flags(1'b0, 1'b1);
    @(posedge clk);
    tx_rd <= 1'b1;
    rx_rd <= 1'b1;
    for (int k = 0; k < DEPTH; k++) begin
      @(negedge clk);
      check_flag("o_tx_empty", tx_empty, 1'b0);
      check_flag("o_rx_empty", rx_empty, 1'b0);
      check_byte("o_tx_data", tx_data, tx_model.pop_front());
      check_byte("o_rx_data", rx_data, rx_model.pop_front());
      @(posedge clk);
    end
    @(negedge clk);
    check_queue_flags(1'b1, 1'b0);
    @(posedge clk);
    tx_rd <= 1'b0;  // One read on an empty queue was sampled here
    rx_rd <= 1'b0;
    tx_wr <= {1'b1, 8'h3C};
    rx_wr <= {1'b1, 8'hC3};
    @(posedge clk);
    tx_wr <= '0;
    rx_wr <= '0;
    @(negedge clk);
    check_queue_flags(1'b0, 1'b0);
    check_byte("o_tx_data", tx_data, 8'h3C);
    check_byte("o_rx_data", rx_data, 8'hC3);
  endtask

  initial begin
    void'($urandom(32'h50c111a2));
    rst_n = 1'b0;
    ether_en = 1'b1;
    app_ip = '0;
    app_cpu = '0;
    rxbuf_ip = '0;
    rxbuf_cpu = '0;
    txbuf_ip = '0;
    txbuf_cpu = '0;
    tx_wr = '0;
    rx_wr = '0;
    tx_rd = 1'b0;
    rx_rd = 1'b0;
    // en  ip_req ip_rel cpu_req cpu_rel  rx_ip rx_cpu tx_ip tx_cpu
    add_row(1, 1, 0, 0, 0, 0, 0, 0, 0);
    add_row(1, 0, 0, 0, 1, 0, 0, 0, 0);
    add_row(1, 0, 1, 0, 0, 0, 0, 0, 0);
    add_row(1, 0, 0, 1, 0, 0, 0, 0, 0);
    add_row(1, 0, 0, 0, 1, 0, 0, 0, 0);
    add_row(1, 1, 0, 1, 0, 0, 0, 0, 0);
    add_row(1, 0, 1, 0, 0, 0, 0, 0, 0);
    add_row(1, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row(1, 0, 0, 0, 0, 1, 0, 0, 1);
    add_row(1, 0, 0, 0, 0, 0, 1, 1, 0);
    add_row(0, 0, 0, 1, 0, 1, 0, 0, 0);
    add_row(0, 0, 0, 0, 0, 0, 0, 0, 1);
    add_row(1, 0, 0, 0, 0, 0, 0, 0, 0);
    add_row(1, 0, 0, 0, 1, 0, 1, 0, 0);
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_grant("o_app_grant", app_grant, '{ip: 1'b0, cpu: 1'b0});
    check_grant("o_rxbuf_grant", rxbuf_grant, '{ip: 1'b1, cpu: 1'b0});
    check_grant("o_txbuf_grant", txbuf_grant, '{ip: 1'b0, cpu: 1'b1});
    check_queue_flags(1'b1, 1'b0);
    run_table();
    run_queue_test();
    if (uut.props.fail_count == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1, "Property checks failed");
    end
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+design
design/share_pkg.sv
design/app_data_arbiter.sv
design/buf_owner_toggle.sv
design/byte_queue.sv
design/ros2_share_top.sv
dv/ros2_share_props.sv
dv/tb_ros2_share.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ros2_share
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
RUN_ARGS  ?= +verilator+error+limit+10
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# The result is decided by the pass line in the simulator output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
